//--- hw/capi_pkg.sv
package capi_pkg;

  // --------------------------------------------------------------------------
  // Line and field sizes on the host port
  // --------------------------------------------------------------------------
  localparam int CACHELINE_BITS = 1024;  // One full cache line
  localparam int HALF_LINE_BITS = 512;   // One returned half
  localparam int ADDR_BITS      = 64;    // Effective address
  localparam int SIZE_BITS      = 12;    // Command size field, in bytes

  // Size field of a full-line read
  localparam logic [SIZE_BITS-1:0] LINE_BYTES = 12'd128;

  // Tags
  localparam int TAG_BITS    = 3;
  localparam int TAG_ENTRIES = 1 << TAG_BITS;  // Outstanding commands

  // --------------------------------------------------------------------------
  // Command buffer sizing
  // --------------------------------------------------------------------------
  localparam int BUFFER_DEPTH    = 4;
  localparam int BUFFER_PTR_BITS = $clog2(BUFFER_DEPTH);

  // Occupancy levels, one bit wider than the pointers
  localparam logic [BUFFER_PTR_BITS:0] BUFFER_FULL_COUNT = 3'd4;
  localparam logic [BUFFER_PTR_BITS:0] ALFULL_LEVEL      = 3'd3;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------
  typedef enum logic [12:0] {
    INVALID    = 13'h0000,  // Idle command slot
    READ_CL_NA = 13'h0A00   // Full-line read, no allocation
  } cmd_opcode;

  typedef enum logic [7:0] {
    DONE   = 8'h00,
    AERROR = 8'h01,  // Bad address
    FAILED = 8'h08   // Host gave up on the command
  } resp_code;

  // Owner of a command, kept per tag
  typedef enum logic [1:0] {
    INVALID_ID = 2'd0,
    WED_ID     = 2'd1,
    CU_ID      = 2'd2
  } unit_id;

endpackage

//--- hw/wed_pkg.sv
package wed_pkg;

  // --------------------------------------------------------------------------
  // Descriptor fetch states
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    WED_RESET = 3'd0,  // First cycle out of reset
    WED_IDLE  = 3'd1,  // Waiting for enable and buffer room
    WED_REQ   = 3'd2,  // Command goes out
    WED_WAIT  = 3'd3,  // Halves arriving, waiting for DONE
    WED_DONE  = 3'd4   // Record latched
  } wed_state;

  // --------------------------------------------------------------------------
  // Work element descriptor
  // --------------------------------------------------------------------------
  // Declared top field first, so num_vertices ends up in the lowest word
  typedef struct packed {
    logic [63:0] auxiliary;     // Spare pointer for the compute units
    logic [63:0] edge_array;    // Base of the edge list
    logic [63:0] vertex_array;  // Base of the vertex list
    logic [31:0] num_edges;
    logic [31:0] num_vertices;
  } wed_record;

  localparam int WED_RECORD_BITS = $bits(wed_record);  // 256

  // Record starts at bit 0 of the line, i.e. the low end of half 0
  localparam int WED_FIELD_OFFSET = 0;

  // Pull the record out of an assembled line
  function automatic wed_record map_line_to_wed(
    input logic [capi_pkg::CACHELINE_BITS-1:0] line
  );
    wed_record rec;
    rec = line[WED_FIELD_OFFSET +: WED_RECORD_BITS];
    return rec;
  endfunction

endpackage

//--- hw/command_if.sv
interface command_if;

  logic                           valid;    // One-cycle strobe per command
  capi_pkg::cmd_opcode            command;
  logic [capi_pkg::ADDR_BITS-1:0] address;
  logic [capi_pkg::SIZE_BITS-1:0] size;     // Bytes
  capi_pkg::unit_id               unit;     // Owner, stored with the tag
  logic                           alfull;   // Back-pressure toward the source

  // Source side, drives a command and watches the fill level
  modport producer (output valid, command, address, size, unit, input alfull);

  // Write side of the command FIFO
  modport buffer (input valid, command, address, size, unit, output alfull);

  // Sink side, takes what the FIFO hands out
  modport consumer (input valid, command, address, size, unit);

endinterface

//--- hw/command_buffer.sv
module command_buffer (
  input  logic        clock,
  input  logic        rstn,
  command_if.buffer   in,
  command_if.producer out,
  input  logic        pop,
  output logic        empty
);

  // Storage, one array per field
  capi_pkg::cmd_opcode            mem_command [capi_pkg::BUFFER_DEPTH];
  logic [capi_pkg::ADDR_BITS-1:0] mem_address [capi_pkg::BUFFER_DEPTH];
  logic [capi_pkg::SIZE_BITS-1:0] mem_size    [capi_pkg::BUFFER_DEPTH];
  capi_pkg::unit_id               mem_unit    [capi_pkg::BUFFER_DEPTH];

  logic [capi_pkg::BUFFER_PTR_BITS-1:0] wr_ptr;  // Wraps at depth
  logic [capi_pkg::BUFFER_PTR_BITS-1:0] rd_ptr;
  logic [capi_pkg::BUFFER_PTR_BITS:0]   count;   // 0 to depth
  logic                                 full;
  logic                                 push;
  logic                                 take;

  assign full      = (count == capi_pkg::BUFFER_FULL_COUNT);
  assign empty     = (count == '0);
  assign in.alfull = (count >= capi_pkg::ALFULL_LEVEL);
  assign push      = in.valid && !full;
  assign take      = pop && !empty;

  always_ff @(posedge clock) begin
    if (push) begin
      mem_command[wr_ptr] <= in.command;
      mem_address[wr_ptr] <= in.address;
      mem_size[wr_ptr]    <= in.size;
      mem_unit[wr_ptr]    <= in.unit;
    end
  end

  // --------------------------------------------------------------------------
  // Pointers, level and the registered output
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out.valid <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (take) rd_ptr <= rd_ptr + 1'b1;
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
      out.valid <= take;  // Entry shows up the cycle after the pop
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      out.command <= mem_command[rd_ptr];
      out.address <= mem_address[rd_ptr];
      out.size    <= mem_size[rd_ptr];
      out.unit    <= mem_unit[rd_ptr];
    end
  end

  assert property (@(posedge clock) disable iff (!rstn) in.valid |-> !full)
    else $error("command written into full buffer");
  assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
    else $error("pop from empty buffer");

endmodule

//--- hw/read_port.sv
module read_port (
  input  logic                                clock,
  input  logic                                rstn,
  command_if.consumer                         cmd,
  input  logic                                empty,
  output logic                                pop,
  input  logic                                host_ready,
  output logic                                host_cmd_valid,
  output capi_pkg::cmd_opcode                 host_cmd_opcode,
  output logic [capi_pkg::ADDR_BITS-1:0]      host_cmd_address,
  output logic [capi_pkg::SIZE_BITS-1:0]      host_cmd_size,
  output logic [capi_pkg::TAG_BITS-1:0]       host_cmd_tag,
  input  logic                                host_data_valid,
  input  logic                                host_data_half,
  input  logic [capi_pkg::TAG_BITS-1:0]       host_data_tag,
  input  logic [capi_pkg::HALF_LINE_BITS-1:0] host_data,
  input  logic                                host_resp_valid,
  input  logic [capi_pkg::TAG_BITS-1:0]       host_resp_tag,
  input  capi_pkg::resp_code                  host_resp_code,
  output logic                                data0_valid,
  output logic                                data1_valid,
  output capi_pkg::unit_id                    data_unit,
  output logic [capi_pkg::HALF_LINE_BITS-1:0] data_line,
  output logic                                resp_valid,
  output capi_pkg::unit_id                    resp_unit,
  output capi_pkg::resp_code                  resp_code
);

  logic [capi_pkg::TAG_BITS-1:0]    next_tag;   // Wrapping tag counter
  logic [capi_pkg::TAG_ENTRIES-1:0] tag_live;   // Entry in use
  capi_pkg::unit_id                 tag_unit [capi_pkg::TAG_ENTRIES];
  capi_pkg::unit_id                 data_owner;
  capi_pkg::unit_id                 resp_owner;

  // Pop only while the host takes commands
  // Issue lands one cycle later
  assign pop              = host_ready && !empty;
  assign host_cmd_valid   = cmd.valid;
  assign host_cmd_opcode  = cmd.command;
  assign host_cmd_address = cmd.address;
  assign host_cmd_size    = cmd.size;
  assign host_cmd_tag     = next_tag;

  // Stale or foreign tags go back as nobody's
  assign data_owner = tag_live[host_data_tag] ? tag_unit[host_data_tag] : capi_pkg::INVALID_ID;
  assign resp_owner = tag_live[host_resp_tag] ? tag_unit[host_resp_tag] : capi_pkg::INVALID_ID;

  // --------------------------------------------------------------------------
  // Tag table
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      next_tag <= '0;
      tag_live <= '0;
    end else begin
      // A failed read stays outstanding until DONE frees its tag
      if (host_resp_valid && host_resp_code == capi_pkg::DONE) begin
        tag_live[host_resp_tag] <= 1'b0;
      end
      if (cmd.valid) begin
        tag_live[next_tag] <= 1'b1;  // New issue wins over a same-cycle clear
        next_tag           <= next_tag + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (cmd.valid) tag_unit[next_tag] <= cmd.unit;
  end

  // --------------------------------------------------------------------------
  // Return routing through one register stage
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      data0_valid <= 1'b0;
      data1_valid <= 1'b0;
      resp_valid  <= 1'b0;
    end else begin
      data0_valid <= host_data_valid && !host_data_half;
      data1_valid <= host_data_valid && host_data_half;
      resp_valid  <= host_resp_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (host_data_valid) begin
      data_unit <= data_owner;
      data_line <= host_data;
    end
    if (host_resp_valid) begin
      resp_unit <= resp_owner;
      resp_code <= host_resp_code;
    end
  end

  // Wrapping counter must not land on a tag still outstanding
  assert property (@(posedge clock) disable iff (!rstn) cmd.valid |-> !tag_live[next_tag])
    else $error("tag issued while still in use");

endmodule

//--- hw/wed_control.sv
module wed_control (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                enable,
  input  logic [capi_pkg::ADDR_BITS-1:0]      wed_address,
  command_if.producer                         cmd,
  input  logic                                data0_valid,
  input  logic                                data1_valid,
  input  capi_pkg::unit_id                    data_unit,
  input  logic [capi_pkg::HALF_LINE_BITS-1:0] data_line,
  input  logic                                resp_valid,
  input  capi_pkg::unit_id                    resp_unit,
  input  capi_pkg::resp_code                  resp_code,
  output logic                                wed_valid,
  output wed_pkg::wed_record                  wed_out
);

  wed_pkg::wed_state                 state;
  wed_pkg::wed_state                 next_state;
  logic                              enabled;    // Registered enable
  logic                              resp_done;  // Our read came back clean
  logic [capi_pkg::CACHELINE_BITS-1:0] wed_line; // Assembled descriptor line

  // --------------------------------------------------------------------------
  // Enable and state register
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
      state   <= wed_pkg::WED_RESET;
    end else begin
      enabled <= enable;
      state   <= next_state;
    end
  end

  assign resp_done = resp_valid && resp_unit == capi_pkg::WED_ID &&
                     resp_code == capi_pkg::DONE;  // Any other code keeps waiting

  always_comb begin
    next_state = state;
    case (state)
      wed_pkg::WED_RESET: next_state = wed_pkg::WED_IDLE;
      wed_pkg::WED_IDLE: begin
        // One fetch per reset, and only with room in the buffer
        if (enabled && !wed_valid && !cmd.alfull) begin
          next_state = wed_pkg::WED_REQ;
        end
      end
      wed_pkg::WED_REQ:  next_state = wed_pkg::WED_WAIT;
      wed_pkg::WED_WAIT: begin
        if (resp_done) begin
          next_state = wed_pkg::WED_DONE;
        end
      end
      wed_pkg::WED_DONE: next_state = wed_pkg::WED_IDLE;  // wed_valid blocks refetch
      default:           next_state = wed_pkg::WED_RESET;
    endcase
  end

  // --------------------------------------------------------------------------
  // Command out
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= (state == wed_pkg::WED_REQ);  // Single-cycle strobe
    end
  end

  always_ff @(posedge clock) begin
    if (state == wed_pkg::WED_REQ) begin
      cmd.command <= capi_pkg::READ_CL_NA;
      cmd.address <= wed_address;
      cmd.size    <= capi_pkg::LINE_BYTES;  // Whole line
      cmd.unit    <= capi_pkg::WED_ID;
    end
  end

  // --------------------------------------------------------------------------
  // Line assembly and record
  // --------------------------------------------------------------------------
  // Half 0 fills the low bits, half 1 the high bits
  always_ff @(posedge clock) begin
    if (state == wed_pkg::WED_WAIT && data_unit == capi_pkg::WED_ID) begin
      if (data0_valid) begin
        wed_line[capi_pkg::HALF_LINE_BITS-1:0] <= data_line;
      end
      if (data1_valid) begin
        wed_line[capi_pkg::CACHELINE_BITS-1:capi_pkg::HALF_LINE_BITS] <= data_line;
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wed_valid <= 1'b0;
    end else if (state == wed_pkg::WED_DONE) begin
      wed_valid <= 1'b1;  // Sticky until reset
    end
  end

  always_ff @(posedge clock) begin
    if (state == wed_pkg::WED_DONE) begin
      wed_out <= wed_pkg::map_line_to_wed(wed_line);
    end
  end

  // Buffer level was checked in idle, nobody else fills it in between
  assert property (@(posedge clock) disable iff (!rstn) cmd.valid |-> !cmd.alfull)
    else $error("command strobe while buffer almost full");

endmodule

//--- hw/wed_top.sv
module wed_top (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                enable,
  input  logic [capi_pkg::ADDR_BITS-1:0]      wed_address,
  input  logic                                host_ready,
  output logic                                host_cmd_valid,
  output capi_pkg::cmd_opcode                 host_cmd_opcode,
  output logic [capi_pkg::ADDR_BITS-1:0]      host_cmd_address,
  output logic [capi_pkg::SIZE_BITS-1:0]      host_cmd_size,
  output logic [capi_pkg::TAG_BITS-1:0]       host_cmd_tag,
  input  logic                                host_data_valid,
  input  logic                                host_data_half,
  input  logic [capi_pkg::TAG_BITS-1:0]       host_data_tag,
  input  logic [capi_pkg::HALF_LINE_BITS-1:0] host_data,
  input  logic                                host_resp_valid,
  input  logic [capi_pkg::TAG_BITS-1:0]       host_resp_tag,
  input  capi_pkg::resp_code                  host_resp_code,
  output logic                                wed_valid,
  output logic [wed_pkg::WED_RECORD_BITS-1:0] wed_out
);

  command_if wed_cmd ();    // Controller into the buffer
  command_if issue_cmd ();  // Buffer out to the read port

  logic                                buffer_empty;
  logic                                buffer_pop;
  logic                                data0_valid;
  logic                                data1_valid;
  capi_pkg::unit_id                    data_unit;
  logic [capi_pkg::HALF_LINE_BITS-1:0] data_line;
  logic                                resp_valid;
  capi_pkg::unit_id                    resp_unit;
  capi_pkg::resp_code                  resp_code;

  wed_control u_wed_control (
    .clock, .rstn, .enable, .wed_address,
    .cmd         (wed_cmd.producer),
    .data0_valid, .data1_valid, .data_unit, .data_line,
    .resp_valid, .resp_unit, .resp_code,
    .wed_valid,
    .wed_out     (wed_out)  // Record flattened to 256 bits
  );

  command_buffer u_command_buffer (
    .clock, .rstn,
    .in    (wed_cmd.buffer),
    .out   (issue_cmd.producer),
    .pop   (buffer_pop),
    .empty (buffer_empty)
  );

  read_port u_read_port (
    .clock, .rstn,
    .cmd   (issue_cmd.consumer),
    .empty (buffer_empty),
    .pop   (buffer_pop),
    .host_ready,
    .host_cmd_valid, .host_cmd_opcode, .host_cmd_address, .host_cmd_size, .host_cmd_tag,
    .host_data_valid, .host_data_half, .host_data_tag, .host_data,
    .host_resp_valid, .host_resp_tag, .host_resp_code,
    .data0_valid, .data1_valid, .data_unit, .data_line,
    .resp_valid, .resp_unit, .resp_code
  );

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
  output logic clock,
  output logic rstn,
  input  logic reset_req   // Sampled on the falling edge
);

  logic       clk_int  = 1'b0;
  logic       rstn_int = 1'b0;  // Low from power-up
  logic [1:0] low_left = 2'd2;  // Falling edges of reset still to go

  assign clock = clk_int;
  assign rstn  = rstn_int;

  always #4 clk_int = ~clk_int;  // Period 8

  // Reset moves on the falling edge, two rising edges see it low
  always @(negedge clk_int) begin
    if (reset_req) begin
      rstn_int <= 1'b0;
      low_left <= 2'd2;
    end else if (low_left != 2'd0) begin
      low_left <= low_left - 2'd1;
      rstn_int <= (low_left == 2'd1);  // Release on the last one
    end
  end

endmodule

//--- testbench/wed_tb.sv
module wed_tb;

  localparam int          NUM_ROWS       = 5;
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * 60;  // A row needs about 40
  localparam logic [31:0] LFSR_SEED      = 32'h32f4_7a55;
  localparam logic [31:0] LFSR_MASK      = 32'h8020_0003;  // x^32+x^22+x^2+x+1

  typedef struct packed {
    logic [63:0]        address;
    logic [7:0]         stall;        // Cycles with host_ready low
    logic               foreign;      // Extra half on an unused tag
    capi_pkg::resp_code first_code;
    logic               early_valid;  // wed_valid after the first response
  } row_t;

  logic          clock;
  logic          rstn;
  logic          reset_req;
  logic          enable;
  logic [63:0]   wed_address;
  logic          host_ready;
  logic          host_cmd_valid;
  capi_pkg::cmd_opcode host_cmd_opcode;
  logic [63:0]   host_cmd_address;
  logic [11:0]   host_cmd_size;
  logic [2:0]    host_cmd_tag;
  logic          host_data_valid;
  logic          host_data_half;
  logic [2:0]    host_data_tag;
  logic [511:0]  host_data;
  logic          host_resp_valid;
  logic [2:0]    host_resp_tag;
  capi_pkg::resp_code host_resp_code;
  logic          wed_valid;
  logic [255:0]  wed_out;

  row_t          rows [NUM_ROWS];
  logic [1023:0] line;         // Line the host returns this row
  logic [31:0]   lfsr_state;
  int            error_count;
  int            bad_rows;
  int            cmd_count;    // Host commands since reset
  int            cycle_count;

  tb_clock clock_gen (.clock, .rstn, .reset_req);

  wed_top dut (.*);

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) next = next ^ LFSR_MASK;  // Galois taps
    return next;
  endfunction

  task automatic fill_line();
    for (int b = 0; b < 1024; b++) begin
      line[b]    = lfsr_state[0];  // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic report_problem(input string what);
    error_count++;
    $display("Problem at %0t: %s", $time, what);
  endtask

  task automatic send_response(input logic [2:0] tag, input capi_pkg::resp_code code);
    host_resp_valid <= 1'b1;
    host_resp_tag   <= tag;
    host_resp_code  <= code;
    @(negedge clock);
    host_resp_valid <= 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Host model from the issued command to the sticky record
  // --------------------------------------------------------------------------
  task automatic answer_command(input row_t r);
    logic [2:0] tag;
    int         waited;
    check_value("host_cmd_opcode", host_cmd_opcode, capi_pkg::READ_CL_NA);
    check_value("host_cmd_address", host_cmd_address, r.address);
    check_value("host_cmd_size", host_cmd_size, 128);  // Full line in bytes
    check_value("host_cmd_tag", host_cmd_tag, 0);      // First tag after reset
    tag = host_cmd_tag;
    @(negedge clock);
    host_data_valid <= 1'b1;
    host_data_half  <= 1'b0;
    host_data_tag   <= tag;
    host_data       <= line[511:0];     // Half 0 in the low bits
    @(negedge clock);
    host_data_half  <= 1'b1;
    host_data       <= line[1023:512];
    @(negedge clock);
    host_data_valid <= r.foreign;
    host_data_half  <= 1'b0;
    host_data_tag   <= tag + 3'd4;      // Never issued in this row
    host_data       <= ~line[511:0];    // Would corrupt every record bit
    @(negedge clock);
    host_data_valid <= 1'b0;
    send_response(tag, r.first_code);
    repeat (3) @(negedge clock);
    check_value("wed_valid", wed_valid, r.early_valid);
    if (r.first_code != capi_pkg::DONE) send_response(tag, capi_pkg::DONE);  // Same tag
    waited = 0;
    while (!wed_valid && waited < 3) begin
      @(negedge clock);
      waited++;
    end
    if (!wed_valid) report_problem("wed_valid did not rise within 4 cycles of DONE");
    check_value("wed_out", wed_out, line[255:0]);  // Record sits at the line's bottom
    repeat (3) begin
      @(negedge clock);
      check_value("wed_valid", wed_valid, 1'b1);    // Sticky
    end
    check_value("host command count", cmd_count, 1);
  endtask

  task automatic run_row(input int i);
    row_t r;
    int   errors_before;
    int   waited;
    logic found;
    r = rows[i];
    errors_before = error_count;
    fill_line();
    @(negedge clock);
    enable      <= 1'b0;
    host_ready  <= 1'b0;
    wed_address <= r.address;
    reset_req   <= 1'b1;
    @(negedge clock);
    reset_req   <= 1'b0;
    @(posedge rstn);
    @(negedge clock);
    enable      <= 1'b1;
    host_ready  <= (r.stall == 0);
    for (int c = 0; c < r.stall; c++) begin
      @(negedge clock);
      check_value("host_cmd_valid", host_cmd_valid, 1'b0);  // Held in the buffer
    end
    host_ready <= 1'b1;
    found  = 1'b0;
    waited = 0;
    while (!found && waited < 6) begin
      @(negedge clock);
      waited++;
      found = host_cmd_valid;
    end
    if (found) answer_command(r);
    else report_problem("no host command within 6 cycles");
    if (error_count == errors_before) begin
      $display("Row %0d at %h: passed", i, r.address);
    end else begin
      bad_rows++;
      $display("Row %0d at %h: %0d errors", i, r.address, error_count - errors_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // Monitor, timeout and the run
  // --------------------------------------------------------------------------
  always @(negedge clock) begin
    if (!rstn) cmd_count <= 0;
    else if (host_cmd_valid) cmd_count <= cmd_count + 1;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    reset_req       = 1'b0;
    enable          = 1'b0;
    wed_address     = '0;
    host_ready      = 1'b0;
    host_data_valid = 1'b0;
    host_data_half  = 1'b0;
    host_data_tag   = '0;
    host_data       = '0;
    host_resp_valid = 1'b0;
    host_resp_tag   = '0;
    host_resp_code  = capi_pkg::DONE;
    lfsr_state      = LFSR_SEED;
    error_count     = 0;
    bad_rows        = 0;
    rows[0] = '{64'h0000_1000_0000_0080, 8'd0, 1'b0, capi_pkg::DONE,   1'b1};  // Plain
    rows[1] = '{64'h0000_7f00_0012_3400, 8'd0, 1'b1, capi_pkg::DONE,   1'b1};  // Foreign
    rows[2] = '{64'hffff_8000_0000_0f80, 8'd9, 1'b0, capi_pkg::DONE,   1'b1};  // Stall
    rows[3] = '{64'h0000_0000_dead_be00, 8'd0, 1'b0, capi_pkg::FAILED, 1'b0};
    rows[4] = '{64'h0123_4567_89ab_cd80, 8'd5, 1'b1, capi_pkg::AERROR, 1'b0};  // All at once
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    $display("%0d rows run, %0d with errors, %0d errors in total",
             NUM_ROWS, bad_rows, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- flist.f
hw/capi_pkg.sv
hw/wed_pkg.sv
hw/command_if.sv
hw/command_buffer.sv
hw/read_port.sv
hw/wed_control.sv
hw/wed_top.sv
testbench/tb_clock.sv
testbench/wed_tb.sv

//--- Makefile
TOP = wed_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
